// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
logic/csr_pkg.sv
logic/csr_write_select.sv
logic/csr_exception_regs.sv
logic/csr_timer.sv
logic/csr_scratch_read.sv
logic/csr_file.sv
bench/csr_file_tb.sv

// ==== bench/csr_file_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;
    import csr_pkg::*;

    localparam int COUNTER_W = 64;
    localparam int TI_LIMIT  = 200;
    // every mapped register plus two unmapped numbers
    localparam csr_addr_t ADDR_LIST [16] = '{
        CSR_CRMD, CSR_PRMD, CSR_ECTL, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG,
        CSR_TVAL, CSR_TICLR, 14'h7, 14'h3ff
    };

    logic                 clk;
    logic                 rst;
    logic                 wr1_en_i;
    csr_addr_t            wr1_addr_i;
    csr_data_t            wr1_data_i;
    logic                 wr2_en_i;
    csr_addr_t            wr2_addr_i;
    csr_data_t            wr2_data_i;
    csr_addr_t            rd_addr_i;
    csr_data_t            rdata_o;
    logic                 excp_flush_i;
    logic                 ertn_flush_i;
    csr_data_t            era_i;
    ecode_t               ecode_i;
    esubcode_t            esubcode_i;
    int_lines_t           interrupt_i;
    plv_t                 plv_o;
    logic                 has_int_o;
    csr_data_t            eentry_o;
    csr_data_t            era_o;
    csr_data_t            tid_o;
    logic [COUNTER_W-1:0] timer_o;

    // expected register state
    logic [8:0]      crmd_m;
    logic [2:0]      prmd_m;
    logic [IS_W-1:0] ectl_m;
    logic [1:0]      is_sw_m;
    int_lines_t      int_m;
    logic            ti_m;
    ecode_t          ecode_m;
    esubcode_t       esubcode_m;
    csr_data_t       era_m;
    csr_data_t       eentry_m;
    csr_data_t       tid_m;
    csr_data_t       tcfg_m;
    csr_data_t       tval_m;
    csr_data_t       save_m [4];

    logic                 chk_en;
    logic [31:0]          rng;
    logic                 en1;
    logic                 en2;
    csr_addr_t            a1;
    csr_addr_t            a2;
    csr_data_t            d1;
    csr_data_t            d2;
    int                   n;
    int                   edges;
    int_lines_t           int_next;
    logic [COUNTER_W-1:0] prev_count;

    csr_file #(
        .COUNTER_W(COUNTER_W)
    ) csr_file_inst (
        .clk(clk), .rst(rst),
        .wr1_en_i(wr1_en_i), .wr1_addr_i(wr1_addr_i), .wr1_data_i(wr1_data_i),
        .wr2_en_i(wr2_en_i), .wr2_addr_i(wr2_addr_i), .wr2_data_i(wr2_data_i),
        .rd_addr_i(rd_addr_i), .rdata_o(rdata_o),
        .excp_flush_i(excp_flush_i), .ertn_flush_i(ertn_flush_i),
        .era_i(era_i), .ecode_i(ecode_i), .esubcode_i(esubcode_i),
        .interrupt_i(interrupt_i), .plv_o(plv_o), .has_int_o(has_int_o),
        .eentry_o(eentry_o), .era_o(era_o), .tid_o(tid_o), .timer_o(timer_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic csr_data_t expected_read(input csr_addr_t addr);
        case (addr)
            CSR_CRMD:   return {23'b0, crmd_m};
            CSR_PRMD:   return {29'b0, prmd_m};
            CSR_ECTL:   return {19'b0, ectl_m};
            CSR_ESTAT:  return {1'b0, esubcode_m, ecode_m, 3'b0, 1'b0, ti_m, int_m, is_sw_m};
            CSR_ERA:    return era_m;
            CSR_EENTRY: return eentry_m;
            CSR_SAVE0:  return save_m[0];
            CSR_SAVE1:  return save_m[1];
            CSR_SAVE2:  return save_m[2];
            CSR_SAVE3:  return save_m[3];
            CSR_TID:    return tid_m;
            CSR_TCFG:   return tcfg_m;
            CSR_TVAL:   return tval_m;
            default:    return '0;
        endcase
    endfunction

    function automatic logic expected_has_int();
        logic [IS_W-1:0] is_vec;
        is_vec = {1'b0, ti_m, int_m, is_sw_m};
        return (|(is_vec & ectl_m)) && crmd_m[2];
    endfunction

    // writable fields only
    task automatic model_write(input csr_addr_t addr, input csr_data_t data);
        case (addr)
            CSR_CRMD:   crmd_m = data[8:0];
            CSR_PRMD:   prmd_m = data[2:0];
            CSR_ECTL:   ectl_m = data[12:0] & 13'h1bff;
            CSR_ESTAT:  is_sw_m = data[1:0];
            CSR_ERA:    era_m = data;
            CSR_EENTRY: eentry_m = {data[31:6], 6'b0};
            CSR_SAVE0:  save_m[0] = data;
            CSR_SAVE1:  save_m[1] = data;
            CSR_SAVE2:  save_m[2] = data;
            CSR_SAVE3:  save_m[3] = data;
            CSR_TID:    tid_m = data;
            CSR_TCFG: begin
                tcfg_m = data;
                tval_m = {data[31:2], 2'b00};
            end
            CSR_TICLR: begin
                if (data[0]) begin
                    ti_m = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", TI_LIMIT, what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // port 1 wins when both are enabled
    task automatic write_two(input logic e1, input csr_addr_t x1, input csr_data_t v1,
                             input logic e2, input csr_addr_t x2, input csr_data_t v2);
        csr_addr_t win_addr;
        csr_data_t win_data;
        plv_t      plv_exp;
        win_addr = e1 ? x1 : x2;
        win_data = e1 ? v1 : v2;
        plv_exp  = (win_addr == CSR_CRMD) ? win_data[1:0] : crmd_m[1:0];
        @(posedge clk);
        wr1_en_i   <= e1;
        wr1_addr_i <= x1;
        wr1_data_i <= v1;
        wr2_en_i   <= e2;
        wr2_addr_i <= x2;
        wr2_data_i <= v2;
        @(negedge clk);
        check("plv_o", 64'(plv_o), 64'(plv_exp));
        @(posedge clk);
        wr1_en_i <= 1'b0;
        wr2_en_i <= 1'b0;
        model_write(win_addr, win_data);
    endtask

    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        write_two(1'b1, addr, data, 1'b0, '0, '0);
    endtask

    task automatic read_check(input csr_addr_t addr);
        @(posedge clk);
        rd_addr_i <= addr;
        chk_en    <= 1'b1;
        @(posedge clk);
        chk_en    <= 1'b0;
    endtask

    task automatic enter_exception(input csr_data_t era, input ecode_t ecode,
                                   input esubcode_t esub);
        @(posedge clk);
        excp_flush_i <= 1'b1;
        era_i        <= era;
        ecode_i      <= ecode;
        esubcode_i   <= esub;
        @(negedge clk);
        check("plv_o", 64'(plv_o), 64'd0);
        @(posedge clk);
        excp_flush_i <= 1'b0;
        prmd_m      = crmd_m[2:0];
        crmd_m[2:0] = 3'b000;
        era_m       = era;
        ecode_m     = ecode;
        esubcode_m  = esub;
        read_check(CSR_CRMD);
        read_check(CSR_PRMD);
        read_check(CSR_ERA);
        read_check(CSR_ESTAT);
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn_flush_i <= 1'b1;
        @(negedge clk);
        check("plv_o", 64'(plv_o), 64'(prmd_m[1:0]));
        @(posedge clk);
        ertn_flush_i <= 1'b0;
        crmd_m[2:0] = prmd_m;
        read_check(CSR_CRMD);
    endtask

    // rd_addr_i must already select ESTAT
    task automatic wait_ti(output int count);
        logic seen;
        count = 0;
        seen  = 1'b0;
        while (!seen && count < TI_LIMIT) begin
            @(posedge clk);
            count++;
            @(negedge clk);
            seen = rdata_o[TI_BIT];
        end
        if (!seen) begin
            stop_on_timeout("the timer interrupt");
        end
    endtask

    always @(negedge clk) begin
        if (chk_en) begin
            check("rdata_o", 64'(rdata_o), 64'(expected_read(rd_addr_i)));
            check("plv_o", 64'(plv_o), 64'(crmd_m[1:0]));
            check("tid_o", 64'(tid_o), 64'(tid_m));
            check("era_o", 64'(era_o), 64'(era_m));
            check("eentry_o", 64'(eentry_o), 64'(eentry_m));
        end
    end

    initial begin
        rst          = 1'b1;
        wr1_en_i     = 1'b0;
        wr1_addr_i   = '0;
        wr1_data_i   = '0;
        wr2_en_i     = 1'b0;
        wr2_addr_i   = '0;
        wr2_data_i   = '0;
        rd_addr_i    = '0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
        era_i        = '0;
        ecode_i      = '0;
        esubcode_i   = '0;
        interrupt_i  = '0;
        chk_en       = 1'b0;
        rng          = 32'h8380_dd13;
        crmd_m       = 9'h008;
        prmd_m       = '0;
        ectl_m       = '0;
        is_sw_m      = '0;
        int_m        = '0;
        ti_m         = 1'b0;
        ecode_m      = '0;
        esubcode_m   = '0;
        era_m        = '0;
        eentry_m     = '0;
        tid_m        = '0;
        tcfg_m       = '0;
        tval_m       = '1;
        for (int i = 0; i < 4; i++) begin
            save_m[i] = '0;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("has_int_o", 64'(has_int_o), 64'd0);
        check("plv_o", 64'(plv_o), 64'd0);
        check("timer_o", 64'(timer_o), 64'd0);
        read_check(CSR_CRMD);
        read_check(CSR_TVAL);

        // random writes, sometimes on both ports at once
        for (int i = 0; i < 200; i++) begin
            rng = next_random(rng);
            a1  = ADDR_LIST[rng[3:0]];
            a2  = ADDR_LIST[rng[9:6]];
            en1 = rng[4];
            en2 = rng[5] | ~rng[4];
            rng = next_random(rng);
            d1  = rng;
            rng = next_random(rng);
            d2  = rng;
            // keep the timer stopped here
            if (a1 == CSR_TCFG) begin
                d1[0] = 1'b0;
            end
            if (a2 == CSR_TCFG) begin
                d2[0] = 1'b0;
            end
            write_two(en1, a1, d1, en2, a2, d2);
            read_check(en1 ? a1 : a2);
            if (en1 && en2) begin
                read_check(a2);
            end
        end

        for (int k = 0; k < 4; k++) begin
            rng = next_random(rng);
            // ie alternates so both values are saved and restored
            write_reg(CSR_CRMD, {23'b0, rng[8:3], k[0], rng[1:0]});
            rng = next_random(rng);
            enter_exception(rng, rng[5:0], rng[14:6]);
            return_from_exception();
        end

        // one-shot countdown
        rng = next_random(rng);
        n = int'(rng[2:0]) + 1;
        write_reg(CSR_TCFG, {30'(n), 2'b01});
        rd_addr_i <= CSR_ESTAT;
        wait_ti(edges);
        check("rdata_o[11] edges", 64'(edges), 64'(4 * n + 1));
        ti_m   = 1'b1;
        tval_m = '1;
        read_check(CSR_TVAL);
        read_check(CSR_ESTAT);
        write_reg(CSR_TICLR, 32'h1);
        read_check(CSR_ESTAT);

        // periodic countdown
        rng = next_random(rng);
        n = int'(rng[2:0]) + 1;
        write_reg(CSR_TCFG, {30'(n), 2'b11});
        rd_addr_i <= CSR_ESTAT;
        wait_ti(edges);
        check("rdata_o[11] edges", 64'(edges), 64'(4 * n + 1));
        write_reg(CSR_TICLR, 32'h1);
        wait_ti(edges);
        check("rdata_o[11] period", 64'(edges + 2), 64'(4 * n + 1));
        ti_m = 1'b1;
        write_reg(CSR_TCFG, 32'h0);
        write_reg(CSR_TICLR, 32'h1);
        read_check(CSR_TVAL);
        read_check(CSR_ESTAT);

        // interrupt detection
        for (int k = 0; k < 32; k++) begin
            rng = next_random(rng);
            write_reg(CSR_ECTL, rng);
            rng = next_random(rng);
            write_reg(CSR_CRMD, rng);
            rng = next_random(rng);
            write_reg(CSR_ESTAT, rng[2] ? rng : 32'h0);
            rng = next_random(rng);
            int_next = rng[8:0] & rng[20:12];
            @(posedge clk);
            interrupt_i <= int_next;
            @(negedge clk);
            check("has_int_o", 64'(has_int_o), 64'(expected_has_int()));
            @(posedge clk);
            int_m = int_next;
            @(negedge clk);
            check("has_int_o", 64'(has_int_o), 64'(expected_has_int()));
            read_check(CSR_ESTAT);
        end

        @(negedge clk);
        prev_count = timer_o;
        repeat (16) begin
            @(negedge clk);
            check("timer_o step", 64'(timer_o - prev_count), 64'd1);
            prev_count = timer_o;
        end
        read_check(CSR_TID);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/csr_exception_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_exception_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sel_crmd_i,
    input  logic                  sel_prmd_i,
    input  logic                  sel_ectl_i,
    input  logic                  sel_estat_i,
    input  logic                  sel_era_i,
    input  logic                  sel_eentry_i,
    input  csr_pkg::csr_data_t    wr_data_i,
    input  logic                  excp_flush_i,
    input  logic                  ertn_flush_i,
    input  csr_pkg::csr_data_t    era_i,
    input  csr_pkg::ecode_t       ecode_i,
    input  csr_pkg::esubcode_t    esubcode_i,
    input  csr_pkg::int_lines_t   interrupt_i,
    input  logic                  timer_int_i,
    output csr_pkg::csr_data_t    crmd_o,
    output csr_pkg::csr_data_t    prmd_o,
    output csr_pkg::csr_data_t    ectl_o,
    output csr_pkg::csr_data_t    estat_o,
    output csr_pkg::csr_data_t    era_o,
    output csr_pkg::csr_data_t    eentry_o,
    output csr_pkg::plv_t         plv_o,
    output logic                  has_int_o
);
    import csr_pkg::*;

    // bit 10 of LIE is reserved
    localparam logic [IS_W-1:0] LIE_MASK = 13'h1bff;

    // crmd: datm[8:7] datf[6:5] pg[4] da[3] ie[2] plv[1:0]
    logic [8:0]      crmd_q;
    // prmd: pie[2] pplv[1:0]
    logic [2:0]      prmd_q;
    logic [IS_W-1:0] ectl_q;
    logic [1:0]      is_sw_q;
    int_lines_t      int_q;
    ecode_t          ecode_q;
    esubcode_t       esubcode_q;
    csr_data_t       era_q;
    logic [25:0]     eentry_q;
    logic [IS_W-1:0] is_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= 9'b0_0000_1000;
        end else if (excp_flush_i) begin
            crmd_q[2:0] <= 3'b000;
        end else if (ertn_flush_i) begin
            crmd_q[2:0] <= prmd_q;
        end else if (sel_crmd_i) begin
            crmd_q <= wr_data_i[8:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (excp_flush_i) begin
            prmd_q <= crmd_q[2:0];
        end else if (sel_prmd_i) begin
            prmd_q <= wr_data_i[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_q <= '0;
        end else if (sel_ectl_i) begin
            ectl_q <= wr_data_i[IS_W-1:0] & LIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            is_sw_q    <= '0;
            int_q      <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            // hw lines sampled every cycle
            int_q <= interrupt_i;
            if (excp_flush_i) begin
                ecode_q    <= ecode_i;
                esubcode_q <= esubcode_i;
            end else if (sel_estat_i) begin
                is_sw_q <= wr_data_i[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era_q    <= '0;
            eentry_q <= '0;
        end else begin
            if (excp_flush_i) begin
                era_q <= era_i;
            end else if (sel_era_i) begin
                era_q <= wr_data_i;
            end
            if (sel_eentry_i) begin
                eentry_q <= wr_data_i[31:6];
            end
        end
    end

    // interrupt status, bit 12 stays zero
    always_comb begin
        is_vec         = '0;
        is_vec[1:0]    = is_sw_q;
        is_vec[10:2]   = int_q;
        is_vec[TI_BIT] = timer_int_i;
    end

    assign crmd_o   = {23'b0, crmd_q};
    assign prmd_o   = {29'b0, prmd_q};
    assign ectl_o   = {{(32 - IS_W){1'b0}}, ectl_q};
    assign estat_o  = {1'b0, esubcode_q, ecode_q, 3'b0, is_vec};
    assign era_o    = era_q;
    assign eentry_o = {eentry_q, 6'b0};

    assign has_int_o = (|(ectl_q & is_vec)) & crmd_q[2];

    // forwarded privilege level
    always_comb begin
        if (excp_flush_i) begin
            plv_o = '0;
        end else if (ertn_flush_i) begin
            plv_o = prmd_q[1:0];
        end else if (sel_crmd_i) begin
            plv_o = wr_data_i[1:0];
        end else begin
            plv_o = crmd_q[1:0];
        end
    end

    a_flush_excl: assert property (@(posedge clk) disable iff (rst)
        !(excp_flush_i && ertn_flush_i));

endmodule

`default_nettype wire

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter int COUNTER_W = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr1_en_i,
    input  csr_pkg::csr_addr_t    wr1_addr_i,
    input  csr_pkg::csr_data_t    wr1_data_i,
    input  logic                  wr2_en_i,
    input  csr_pkg::csr_addr_t    wr2_addr_i,
    input  csr_pkg::csr_data_t    wr2_data_i,
    input  csr_pkg::csr_addr_t    rd_addr_i,
    output csr_pkg::csr_data_t    rdata_o,
    input  logic                  excp_flush_i,
    input  logic                  ertn_flush_i,
    input  csr_pkg::csr_data_t    era_i,
    input  csr_pkg::ecode_t       ecode_i,
    input  csr_pkg::esubcode_t    esubcode_i,
    input  csr_pkg::int_lines_t   interrupt_i,
    output csr_pkg::plv_t         plv_o,
    output logic                  has_int_o,
    output csr_pkg::csr_data_t    eentry_o,
    output csr_pkg::csr_data_t    era_o,
    output csr_pkg::csr_data_t    tid_o,
    output logic [COUNTER_W-1:0]  timer_o
);
    import csr_pkg::*;

    csr_data_t  wr_data;
    logic       sel_crmd;
    logic       sel_prmd;
    logic       sel_ectl;
    logic       sel_estat;
    logic       sel_era;
    logic       sel_eentry;
    logic       sel_tid;
    logic       sel_tcfg;
    logic       sel_ticlr;
    logic [3:0] sel_save;
    logic       timer_int;
    csr_data_t  crmd;
    csr_data_t  prmd;
    csr_data_t  ectl;
    csr_data_t  estat;
    csr_data_t  tcfg;
    csr_data_t  tval;

    csr_write_select csr_write_select_inst (
        .clk(clk), .rst(rst),
        .wr1_en_i(wr1_en_i), .wr1_addr_i(wr1_addr_i), .wr1_data_i(wr1_data_i),
        .wr2_en_i(wr2_en_i), .wr2_addr_i(wr2_addr_i), .wr2_data_i(wr2_data_i),
        .wr_data_o(wr_data),
        .sel_crmd_o(sel_crmd), .sel_prmd_o(sel_prmd), .sel_ectl_o(sel_ectl),
        .sel_estat_o(sel_estat), .sel_era_o(sel_era), .sel_eentry_o(sel_eentry),
        .sel_tid_o(sel_tid), .sel_tcfg_o(sel_tcfg), .sel_ticlr_o(sel_ticlr),
        .sel_save_o(sel_save)
    );

    csr_exception_regs csr_exception_regs_inst (
        .clk(clk), .rst(rst),
        .sel_crmd_i(sel_crmd), .sel_prmd_i(sel_prmd), .sel_ectl_i(sel_ectl),
        .sel_estat_i(sel_estat), .sel_era_i(sel_era), .sel_eentry_i(sel_eentry),
        .wr_data_i(wr_data),
        .excp_flush_i(excp_flush_i), .ertn_flush_i(ertn_flush_i),
        .era_i(era_i), .ecode_i(ecode_i), .esubcode_i(esubcode_i),
        .interrupt_i(interrupt_i), .timer_int_i(timer_int),
        .crmd_o(crmd), .prmd_o(prmd), .ectl_o(ectl), .estat_o(estat),
        .era_o(era_o), .eentry_o(eentry_o),
        .plv_o(plv_o), .has_int_o(has_int_o)
    );

    csr_timer #(
        .COUNTER_W(COUNTER_W)
    ) csr_timer_inst (
        .clk(clk), .rst(rst),
        .sel_tid_i(sel_tid), .sel_tcfg_i(sel_tcfg), .sel_ticlr_i(sel_ticlr),
        .wr_data_i(wr_data),
        .tid_o(tid_o), .tcfg_o(tcfg), .tval_o(tval),
        .timer_int_o(timer_int), .counter_o(timer_o)
    );

    csr_scratch_read csr_scratch_read_inst (
        .clk(clk), .rst(rst),
        .sel_save_i(sel_save), .wr_data_i(wr_data), .rd_addr_i(rd_addr_i),
        .crmd_i(crmd), .prmd_i(prmd), .ectl_i(ectl), .estat_i(estat),
        .era_i(era_o), .eentry_i(eentry_o),
        .tid_i(tid_o), .tcfg_i(tcfg), .tval_i(tval),
        .rdata_o(rdata_o)
    );

endmodule

`default_nettype wire

// ==== logic/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // external interrupt lines, ESTAT bits 10..2
    typedef logic [8:0]  int_lines_t;

    typedef enum logic {
        TIMER_OFF,
        TIMER_RUN
    } timer_state_t;

    // register numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECTL   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // timer interrupt position in ESTAT.IS
    localparam int TI_BIT = 11;
    // width of ESTAT.IS and ECTL.LIE
    localparam int IS_W = 13;

endpackage

`default_nettype wire

// ==== logic/csr_scratch_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_scratch_read (
    input  logic               clk,
    input  logic               rst,
    input  logic [3:0]         sel_save_i,
    input  csr_pkg::csr_data_t wr_data_i,
    input  csr_pkg::csr_addr_t rd_addr_i,
    input  csr_pkg::csr_data_t crmd_i,
    input  csr_pkg::csr_data_t prmd_i,
    input  csr_pkg::csr_data_t ectl_i,
    input  csr_pkg::csr_data_t estat_i,
    input  csr_pkg::csr_data_t era_i,
    input  csr_pkg::csr_data_t eentry_i,
    input  csr_pkg::csr_data_t tid_i,
    input  csr_pkg::csr_data_t tcfg_i,
    input  csr_pkg::csr_data_t tval_i,
    output csr_pkg::csr_data_t rdata_o
);
    import csr_pkg::*;

    csr_data_t save_q [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (sel_save_i[i]) begin
                    save_q[i] <= wr_data_i;
                end
            end
        end
    end

    always_comb begin
        case (rd_addr_i)
            CSR_CRMD:   rdata_o = crmd_i;
            CSR_PRMD:   rdata_o = prmd_i;
            CSR_ECTL:   rdata_o = ectl_i;
            CSR_ESTAT:  rdata_o = estat_i;
            CSR_ERA:    rdata_o = era_i;
            CSR_EENTRY: rdata_o = eentry_i;
            CSR_SAVE0:  rdata_o = save_q[0];
            CSR_SAVE1:  rdata_o = save_q[1];
            CSR_SAVE2:  rdata_o = save_q[2];
            CSR_SAVE3:  rdata_o = save_q[3];
            CSR_TID:    rdata_o = tid_i;
            CSR_TCFG:   rdata_o = tcfg_i;
            CSR_TVAL:   rdata_o = tval_i;
            // ticlr and unmapped numbers read zero
            default:    rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer #(
    parameter int COUNTER_W = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sel_tid_i,
    input  logic                 sel_tcfg_i,
    input  logic                 sel_ticlr_i,
    input  csr_pkg::csr_data_t   wr_data_i,
    output csr_pkg::csr_data_t   tid_o,
    output csr_pkg::csr_data_t   tcfg_o,
    output csr_pkg::csr_data_t   tval_o,
    output logic                 timer_int_o,
    output logic [COUNTER_W-1:0] counter_o
);
    import csr_pkg::*;

    timer_state_t         state_q;
    csr_data_t            tid_q;
    // tcfg: initval[31:2] periodic[1] en[0]
    csr_data_t            tcfg_q;
    csr_data_t            tval_q;
    logic                 ti_q;
    logic                 expire;
    logic [COUNTER_W-1:0] counter_q;

    assign expire = (state_q == TIMER_RUN) && (tval_q == '0) && !sel_tcfg_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q  <= '0;
            tcfg_q <= '0;
        end else begin
            if (sel_tid_i) begin
                tid_q <= wr_data_i;
            end
            if (sel_tcfg_i) begin
                tcfg_q <= wr_data_i;
            end
        end
    end

    // countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= TIMER_OFF;
            tval_q  <= '1;
        end else if (sel_tcfg_i) begin
            tval_q  <= {wr_data_i[31:2], 2'b00};
            state_q <= wr_data_i[0] ? TIMER_RUN : TIMER_OFF;
        end else if (expire) begin
            if (tcfg_q[1]) begin
                tval_q <= {tcfg_q[31:2], 2'b00};
            end else begin
                tval_q  <= '1;
                state_q <= TIMER_OFF;
            end
        end else if (state_q == TIMER_RUN) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (sel_ticlr_i && wr_data_i[0]) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    // stable counter
    always_ff @(posedge clk) begin
        if (rst) begin
            counter_q <= '0;
        end else begin
            counter_q <= counter_q + 1'b1;
        end
    end

    assign tid_o       = tid_q;
    assign tcfg_o      = tcfg_q;
    assign tval_o      = tval_q;
    assign timer_int_o = ti_q;
    assign counter_o   = counter_q;

    a_tval_hold: assert property (@(posedge clk) disable iff (rst)
        !$stable(tval_q) |-> $past(state_q == TIMER_RUN || sel_tcfg_i));

endmodule

`default_nettype wire

// ==== logic/csr_write_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_write_select (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr1_en_i,
    input  csr_pkg::csr_addr_t wr1_addr_i,
    input  csr_pkg::csr_data_t wr1_data_i,
    input  logic               wr2_en_i,
    input  csr_pkg::csr_addr_t wr2_addr_i,
    input  csr_pkg::csr_data_t wr2_data_i,
    output csr_pkg::csr_data_t wr_data_o,
    output logic               sel_crmd_o,
    output logic               sel_prmd_o,
    output logic               sel_ectl_o,
    output logic               sel_estat_o,
    output logic               sel_era_o,
    output logic               sel_eentry_o,
    output logic               sel_tid_o,
    output logic               sel_tcfg_o,
    output logic               sel_ticlr_o,
    output logic [3:0]         sel_save_o
);
    import csr_pkg::*;

    logic      wr_en;
    csr_addr_t wr_addr;

    // port 1 wins when both write
    assign wr_en     = wr1_en_i | wr2_en_i;
    assign wr_addr   = wr1_en_i ? wr1_addr_i : wr2_addr_i;
    assign wr_data_o = wr1_en_i ? wr1_data_i : wr2_data_i;

    assign sel_crmd_o    = wr_en && (wr_addr == CSR_CRMD);
    assign sel_prmd_o    = wr_en && (wr_addr == CSR_PRMD);
    assign sel_ectl_o    = wr_en && (wr_addr == CSR_ECTL);
    assign sel_estat_o   = wr_en && (wr_addr == CSR_ESTAT);
    assign sel_era_o     = wr_en && (wr_addr == CSR_ERA);
    assign sel_eentry_o  = wr_en && (wr_addr == CSR_EENTRY);
    assign sel_tid_o     = wr_en && (wr_addr == CSR_TID);
    assign sel_tcfg_o    = wr_en && (wr_addr == CSR_TCFG);
    assign sel_ticlr_o   = wr_en && (wr_addr == CSR_TICLR);
    assign sel_save_o[0] = wr_en && (wr_addr == CSR_SAVE0);
    assign sel_save_o[1] = wr_en && (wr_addr == CSR_SAVE1);
    assign sel_save_o[2] = wr_en && (wr_addr == CSR_SAVE2);
    assign sel_save_o[3] = wr_en && (wr_addr == CSR_SAVE3);

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({sel_crmd_o, sel_prmd_o, sel_ectl_o, sel_estat_o, sel_era_o,
                  sel_eentry_o, sel_tid_o, sel_tcfg_o, sel_ticlr_o, sel_save_o}));

endmodule

`default_nettype wire
